// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the USB receiver testbench with Verilator, runs it into sim.log
# and decides pass or fail by searching the log for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f usb_rx.f --top-module usb_rx_tb \
  --Mdir build -o usb_rx_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./build/usb_rx_sim > sim.log 2>&1
cat sim.log

grep -q "All tests passed!" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== source/usb_line_recovery.sv ====
/*
 * Line state filter and bit clock recovery for the D+/D- pair.
 * Emits one mid-bit line sample per bit, locked to incoming edges.
 */
`timescale 1ns/1ns

module usb_line_recovery #(
  parameter int unsigned OversampleRate = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        usb_dp_i,
  input  logic                        usb_dn_i,
  output usb_rx_pkg::usb_line_sample_t sample_o
);

  localparam int unsigned PhaseW   = (OversampleRate > 1) ? $clog2(OversampleRate) : 1;
  localparam int unsigned MidPhase = OversampleRate / 2 - 1;
  localparam int unsigned LastPhase = OversampleRate - 1;

  logic [1:0]            pair;
  usb_rx_pkg::usb_line_e line_q, line_d;
  logic                  in_trans_q, in_trans_d;
  logic [PhaseW-1:0]     phase_q, phase_d;

  assign pair = {usb_dp_i, usb_dn_i};

  //////////////////////////////////////////////////
  // transition filter
  //////////////////////////////////////////////////

  // the two wires of the pair can change a clock apart, so any change first
  // parks the filter in a transition state for one clock
  // the pair is read again after that, once both wires have settled
  always_comb begin
    line_d     = line_q;
    in_trans_d = 1'b0;
    if (in_trans_q) begin
      line_d = usb_rx_pkg::usb_line_e'(pair);
    end else if (pair != line_q) begin
      in_trans_d = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // bit phase recovery
  //////////////////////////////////////////////////

  // every transition marks a bit edge, so the phase restarts there and the
  // sample is taken half a bit later
  always_comb begin
    if (in_trans_q) begin
      phase_d = '0;
    end else if (phase_q == PhaseW'(LastPhase)) begin
      phase_d = '0;
    end else begin
      phase_d = phase_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_q     <= usb_rx_pkg::LineSe0;
      in_trans_q <= 1'b0;
      phase_q    <= '0;
    end else begin
      line_q     <= line_d;
      in_trans_q <= in_trans_d;
      phase_q    <= phase_d;
    end
  end

  // a long run without edges keeps the phase free-running, one sample per bit
  assign sample_o.valid = (phase_q == PhaseW'(MidPhase));
  assign sample_o.line  = line_q;

endmodule

// ==== source/usb_packet_checker.sv ====
/*
 * PID, CRC and length checks on the de-stuffed bit stream, with token field
 * capture and data byte output. Status is judged at the end of each packet.
 */
`timescale 1ns/1ns

module usb_packet_checker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  usb_rx_pkg::usb_bit_stream_t stream_i,
  output logic                        pkt_end_o,
  output usb_rx_pkg::usb_rx_status_t  status_o,
  output usb_rx_pkg::usb_token_u      token_o,
  output logic [7:0]                  rx_data_o,
  output logic                        rx_data_put_o
);

  logic [8:0]                 pid_q, pid_d;
  logic                       pid_complete, pid_ok;
  logic                       payload_bit;
  logic [1:0]                 pid_class;
  logic                       is_token, is_data, is_handshake;
  logic [4:0]                 crc5_q, crc5_d;
  logic [15:0]                crc16_q, crc16_d;
  logic                       len16_q, len16_d;
  logic [3:0]                 len_q, len_d;
  logic                       token_len_ok, data_len_ok, handshake_len_ok;
  logic [11:0]                tok_sr_q, tok_sr_d;
  usb_rx_pkg::usb_token_u     token_q, token_d;
  logic [8:0]                 data_sr_q, data_sr_d;
  usb_rx_pkg::usb_rx_status_t status_now, status_q;

  //////////////////////////////////////////////////
  // PID capture
  //////////////////////////////////////////////////

  // a sentinel 1 reaches bit 0 once all eight PID bits are in, lsb first
  always_comb begin
    pid_d = pid_q;
    if (stream_i.pkt_start) begin
      pid_d = 9'b1_0000_0000;
    end else if (stream_i.bit_valid && !pid_complete) begin
      pid_d = {stream_i.bit_data, pid_q[8:1]};
    end
  end

  assign pid_complete = pid_q[0];
  assign pid_ok       = pid_complete && (pid_q[4:1] == ~pid_q[8:5]);
  assign payload_bit  = stream_i.bit_valid && pid_complete;

  // the two low PID bits give the packet class
  assign pid_class    = pid_q[2:1];
  assign is_token     = (pid_class == 2'b01);
  assign is_data      = (pid_class == 2'b11);
  assign is_handshake = (pid_class == 2'b10);

  //////////////////////////////////////////////////
  // CRC and length
  //////////////////////////////////////////////////

  // both CRCs run over every payload bit, the packet class picks one later
  always_comb begin
    crc5_d  = crc5_q;
    crc16_d = crc16_q;
    if (stream_i.pkt_start) begin
      crc5_d  = '1;
      crc16_d = '1;
    end else if (payload_bit) begin
      crc5_d  = {crc5_q[3:0], 1'b0} ^
                ({5{stream_i.bit_data ^ crc5_q[4]}} & usb_rx_pkg::Crc5Poly);
      crc16_d = {crc16_q[14:0], 1'b0} ^
                ({16{stream_i.bit_data ^ crc16_q[15]}} & usb_rx_pkg::Crc16Poly);
    end
  end

  // len_q counts modulo 16 and len16_q remembers that 16 bits went by
  always_comb begin
    len16_d = len16_q;
    len_d   = len_q;
    if (stream_i.pkt_start) begin
      len16_d = 1'b0;
      len_d   = '0;
    end else if (payload_bit) begin
      len16_d = len16_q | (&len_q);
      len_d   = len_q + 4'd1;
    end
  end

  assign token_len_ok     = len16_q && (len_q == 4'd0);
  assign data_len_ok      = len16_q && (len_q[2:0] == 3'd0);
  assign handshake_len_ok = !len16_q && (len_q == 4'd0);

  //////////////////////////////////////////////////
  // token fields and data bytes
  //////////////////////////////////////////////////

  // token_q loads on the same clock as the eleventh bit, when the sentinel
  // is one step from the end of the shift register
  always_comb begin
    tok_sr_d = tok_sr_q;
    token_d  = token_q;
    if (stream_i.pkt_start) begin
      tok_sr_d = 12'b1000_0000_0000;
    end else if (payload_bit && is_token && !tok_sr_q[0]) begin
      tok_sr_d = {stream_i.bit_data, tok_sr_q[11:1]};
      if (tok_sr_q[1]) begin
        token_d = {stream_i.bit_data, tok_sr_q[11:2]};
      end
    end
  end

  // a full byte is put out for one clock and the buffer reloads behind it
  always_comb begin
    data_sr_d = data_sr_q;
    if (stream_i.pkt_start || data_sr_q[0]) begin
      data_sr_d = 9'b1_0000_0000;
    end else if (payload_bit && is_data) begin
      data_sr_d = {stream_i.bit_data, data_sr_q[8:1]};
    end
  end

  //////////////////////////////////////////////////
  // status
  //////////////////////////////////////////////////

  always_comb begin
    status_now.pid          = usb_rx_pkg::usb_pid_e'(pid_q[4:1]);
    status_now.valid_pid    = pid_ok;
    status_now.valid_packet = pid_ok && !stream_i.stuff_error &&
                              ((is_handshake && handshake_len_ok) ||
                               (is_token && token_len_ok &&
                                (crc5_q == usb_rx_pkg::Crc5Residue)) ||
                               (is_data && data_len_ok &&
                                (crc16_q == usb_rx_pkg::Crc16Residue)));
    status_now.crc5_error     = is_token && (crc5_q != usb_rx_pkg::Crc5Residue);
    status_now.crc16_error    = is_data && (crc16_q != usb_rx_pkg::Crc16Residue);
    status_now.pid_error      = !pid_ok;
    status_now.bitstuff_error = stream_i.stuff_error;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pid_q     <= '0;
      crc5_q    <= '0;
      crc16_q   <= '0;
      len16_q   <= 1'b0;
      len_q     <= '0;
      tok_sr_q  <= '0;
      token_q   <= '0;
      data_sr_q <= '0;
      status_q  <= '0;
    end else begin
      pid_q     <= pid_d;
      crc5_q    <= crc5_d;
      crc16_q   <= crc16_d;
      len16_q   <= len16_d;
      len_q     <= len_d;
      tok_sr_q  <= tok_sr_d;
      token_q   <= token_d;
      data_sr_q <= data_sr_d;
      // the judgement is kept from the end of one packet to the start of the next
      if (stream_i.pkt_start) begin
        status_q <= '0;
      end else if (stream_i.pkt_end) begin
        status_q <= status_now;
      end
    end
  end

  assign pkt_end_o     = stream_i.pkt_end;
  assign status_o      = stream_i.pkt_end ? status_now : status_q;
  assign token_o       = token_q;
  assign rx_data_o     = data_sr_q[8:1];
  assign rx_data_put_o = data_sr_q[0];

endmodule

// ==== source/usb_packet_framer.sv ====
/*
 * Packet framing on the recovered line samples: sync and EOP detection,
 * NRZI decoding and bit-stuff removal. Feeds a de-stuffed bit stream
 * with start and end markers to the packet checker.
 */
`timescale 1ns/1ns

module usb_packet_framer #(
  parameter int unsigned EopSe0Bits = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  usb_rx_pkg::usb_line_sample_t sample_i,
  output usb_rx_pkg::usb_bit_stream_t  stream_o,
  output logic                         pkt_start_o
);

  logic [11:0] history_q, history_d;
  logic        in_pkt_q, in_pkt_d;
  logic        pkt_start, pkt_end;
  logic        see_sync, see_eop;
  logic [1:0]  prev_line, cur_line;
  logic        both_jk;
  logic        nrzi_valid, nrzi_bit;
  logic [2:0]  ones_q, ones_d;
  logic        stuff_drop, stuff_hit;
  logic        stuff_err_q, stuff_err_d;

  //////////////////////////////////////////////////
  // line history and packet boundaries
  //////////////////////////////////////////////////

  // the six most recent mid-bit samples, newest in the low bits
  assign history_d = sample_i.valid ? {history_q[9:0], sample_i.line} : history_q;

  assign see_sync = (history_q == usb_rx_pkg::SyncPattern);

  // SE0 for the configured number of bit times closes the packet
  assign see_eop = ((EopSe0Bits == 1) && (history_q[1:0] == usb_rx_pkg::LineSe0)) ||
                   (history_q[3:0] == {usb_rx_pkg::LineSe0, usb_rx_pkg::LineSe0});

  always_comb begin
    in_pkt_d = in_pkt_q;
    // a stuff error ends the packet right away, without waiting for a sample
    if (in_pkt_q && stuff_err_q) begin
      in_pkt_d = 1'b0;
    end else if (sample_i.valid) begin
      if (!in_pkt_q && see_sync) begin
        in_pkt_d = 1'b1;
      end else if (in_pkt_q && see_eop) begin
        in_pkt_d = 1'b0;
      end
    end
  end

  assign pkt_start = in_pkt_d & ~in_pkt_q;
  assign pkt_end   = ~in_pkt_d & in_pkt_q;

  //////////////////////////////////////////////////
  // NRZI decode
  //////////////////////////////////////////////////

  // each decoded bit comes from the last two samples, so decoding runs one
  // bit behind the line and the first PID bit shows up after sync is seen
  assign prev_line = history_q[3:2];
  assign cur_line  = history_q[1:0];
  assign both_jk   = ((prev_line == usb_rx_pkg::LineJ) || (prev_line == usb_rx_pkg::LineK)) &&
                     ((cur_line == usb_rx_pkg::LineJ) || (cur_line == usb_rx_pkg::LineK));

  // no change between two bits is a 1, a change is a 0
  assign nrzi_bit   = (prev_line == cur_line);
  assign nrzi_valid = in_pkt_q && sample_i.valid && both_jk;

  //////////////////////////////////////////////////
  // bit-stuff removal
  //////////////////////////////////////////////////

  // count of consecutive ones, saturating at six where a stuffed 0 is due
  always_comb begin
    ones_d = ones_q;
    if (pkt_start || pkt_end) begin
      ones_d = '0;
    end else if (nrzi_valid) begin
      if (!nrzi_bit) begin
        ones_d = '0;
      end else if (ones_q != 3'd6) begin
        ones_d = ones_q + 3'd1;
      end
    end
  end

  // the bit after six ones is dropped, and a seventh one is an error
  assign stuff_drop = (ones_q == 3'd6);
  assign stuff_hit  = nrzi_valid && stuff_drop && nrzi_bit;

  always_comb begin
    stuff_err_d = stuff_err_q;
    if (pkt_start) begin
      stuff_err_d = 1'b0;
    end else if (stuff_hit) begin
      stuff_err_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      history_q   <= {6{usb_rx_pkg::LineK}};
      in_pkt_q    <= 1'b0;
      ones_q      <= '0;
      stuff_err_q <= 1'b0;
    end else begin
      history_q   <= history_d;
      in_pkt_q    <= in_pkt_d;
      ones_q      <= ones_d;
      stuff_err_q <= stuff_err_d;
    end
  end

  assign stream_o.bit_valid   = nrzi_valid && !stuff_drop;
  assign stream_o.bit_data    = nrzi_bit;
  assign stream_o.pkt_start   = pkt_start;
  assign stream_o.pkt_end     = pkt_end;
  assign stream_o.stuff_error = stuff_err_q;

  assign pkt_start_o = pkt_start;

endmodule

// ==== source/usb_rx.sv ====
/*
 * Full-speed USB packet receiver top level. Takes the synchronized D+/D-
 * pair and puts out packet status, token fields and received data bytes.
 */
`timescale 1ns/1ns

module usb_rx #(
  parameter int unsigned OversampleRate = 4,
  parameter int unsigned EopSe0Bits     = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       usb_dp_i,
  input  logic                       usb_dn_i,
  output logic                       pkt_start_o,
  output logic                       pkt_end_o,
  output usb_rx_pkg::usb_rx_status_t status_o,
  output usb_rx_pkg::usb_token_u     token_o,
  output logic [7:0]                 rx_data_o,
  output logic                       rx_data_put_o
);

  usb_rx_pkg::usb_line_sample_t line_sample;
  usb_rx_pkg::usb_bit_stream_t  bit_stream;

  usb_line_recovery #(
    .OversampleRate(OversampleRate)
  ) usb_line_recovery_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .usb_dp_i(usb_dp_i),
    .usb_dn_i(usb_dn_i),
    .sample_o(line_sample)
  );

  usb_packet_framer #(
    .EopSe0Bits(EopSe0Bits)
  ) usb_packet_framer_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .sample_i   (line_sample),
    .stream_o   (bit_stream),
    .pkt_start_o(pkt_start_o)
  );

  usb_packet_checker usb_packet_checker_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stream_i     (bit_stream),
    .pkt_end_o    (pkt_end_o),
    .status_o     (status_o),
    .token_o      (token_o),
    .rx_data_o    (rx_data_o),
    .rx_data_put_o(rx_data_put_o)
  );

endmodule

// ==== source/usb_rx_pkg.sv ====
/*
 * Shared types and constants for the full-speed USB packet receiver.
 * Every stage and the testbench refer to these by scoped names.
 */
package usb_rx_pkg;

  // line state of one mid-bit sample, coded as {D+, D-}
  typedef enum logic [1:0] {
    LineSe0 = 2'b00,
    LineK   = 2'b01,
    LineJ   = 2'b10
  } usb_line_e;

  typedef struct packed {
    logic      valid;
    usb_line_e line;
  } usb_line_sample_t;

  // de-stuffed bit stream with packet framing, one bit per bit_valid
  typedef struct packed {
    logic bit_valid;
    logic bit_data;
    logic pkt_start;
    logic pkt_end;
    logic stuff_error;
  } usb_bit_stream_t;

  typedef enum logic [3:0] {
    PidReserved = 4'b0000,
    PidOut      = 4'b0001,
    PidAck      = 4'b0010,
    PidData0    = 4'b0011,
    PidPing     = 4'b0100,
    PidSof      = 4'b0101,
    PidNyet     = 4'b0110,
    PidData2    = 4'b0111,
    PidSplit    = 4'b1000,
    PidIn       = 4'b1001,
    PidNak      = 4'b1010,
    PidData1    = 4'b1011,
    PidPre      = 4'b1100,
    PidSetup    = 4'b1101,
    PidStall    = 4'b1110,
    PidMdata    = 4'b1111
  } usb_pid_e;

  // the first token bit on the wire is the lsb, so addr sits in the low bits
  typedef struct packed {
    logic [3:0] endp;
    logic [6:0] addr;
  } usb_token_ep_t;

  // SOF reads the same eleven bits as one frame number
  typedef union packed {
    usb_token_ep_t ep;
    logic [10:0]   frame_num;
  } usb_token_u;

  typedef struct packed {
    usb_pid_e pid;
    logic     valid_pid;
    logic     valid_packet;
    logic     crc5_error;
    logic     crc16_error;
    logic     pid_error;
    logic     bitstuff_error;
  } usb_rx_status_t;

  localparam logic [4:0]  Crc5Poly     = 5'b00101;
  localparam logic [4:0]  Crc5Residue  = 5'b01100;
  localparam logic [15:0] Crc16Poly    = 16'h8005;
  localparam logic [15:0] Crc16Residue = 16'h800d;

  // end of sync as seen in the line history, oldest sample in the msbs
  localparam logic [11:0] SyncPattern = {LineK, LineJ, LineK, LineJ, LineK, LineK};

endpackage

// ==== usb_rx.f ====
source/usb_rx_pkg.sv
source/usb_line_recovery.sv
source/usb_packet_framer.sv
source/usb_packet_checker.sv
source/usb_rx.sv
verif/usb_rx_tb.sv

// ==== verif/usb_rx_tb.sv ====
/*
 * Directed testbench for the full-speed USB packet receiver. Drives NRZI
 * packets with sync, stuffing and EOP onto D+/D- and checks status, token
 * fields and data bytes against expected values built from the USB rules.
 */
`timescale 1ns/1ns

module usb_rx_tb;

  // total bits on the line: payload bytes with worst-case stuffing, plus sync,
  // EOP and idle per packet, plus the idle time after reset
  localparam int NumTests      = 6;
  localparam int NumPackets    = 9;
  localparam int PacketBytes   = 35;
  localparam int TotalBits     = PacketBytes * 8 + (PacketBytes * 8) / 6 + NumPackets * 14 + 8;
  localparam int TimeoutCycles = TotalBits * 4 + NumTests * 200;

  logic clk_i;
  logic rst_ni;
  logic usb_dp_i;
  logic usb_dn_i;
  logic pkt_start_o;
  logic pkt_end_o;
  usb_rx_pkg::usb_rx_status_t status_o;
  usb_rx_pkg::usb_token_u     token_o;
  logic [7:0] rx_data_o;
  logic       rx_data_put_o;

  usb_rx #(
    .OversampleRate(4),
    .EopSe0Bits    (2)
  ) usb_rx_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .usb_dp_i     (usb_dp_i),
    .usb_dn_i     (usb_dn_i),
    .pkt_start_o  (pkt_start_o),
    .pkt_end_o    (pkt_end_o),
    .status_o     (status_o),
    .token_o      (token_o),
    .rx_data_o    (rx_data_o),
    .rx_data_put_o(rx_data_put_o)
  );

  usb_rx_pkg::usb_line_e      line_state;
  usb_rx_pkg::usb_rx_status_t last_status;
  logic [7:0]  tx_bytes[$];
  logic [7:0]  rx_bytes[$];
  logic [31:0] rng_state = 32'h82a6d865;
  int start_count = 0;
  int end_count   = 0;
  int base_start;
  int base_end;
  int cycle_count = 0;
  int checks      = 0;
  int errors      = 0;

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // monitor and timeout
  //////////////////////////////////////////////////

  // status_o is only meaningful in the pkt_end_o cycle, so it is captured there
  always @(posedge clk_i) begin
    if (pkt_start_o) start_count <= start_count + 1;
    if (pkt_end_o) begin
      end_count   <= end_count + 1;
      last_status <= status_o;
    end
    if (rx_data_put_o) rx_bytes.push_back(rx_data_o);
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("run stopped: timeout after %0d clocks", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // reference rules and stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // a PID goes out with its complement in the upper nibble
  function automatic logic [7:0] pid_byte(input usb_rx_pkg::usb_pid_e p);
    return {~p, p};
  endfunction

  // CRC5 over the 11 token bits, lsb first, complemented and sent msb first
  task automatic build_token(input usb_rx_pkg::usb_pid_e p, input logic [10:0] payload,
                             input bit corrupt);
    logic [4:0]  crc;
    logic [15:0] w;
    logic        fb;
    int          i;
    crc = '1;
    for (i = 0; i < 11; i++) begin
      fb  = payload[i] ^ crc[4];
      crc = {crc[3:0], 1'b0} ^ ({5{fb}} & usb_rx_pkg::Crc5Poly);
    end
    crc = ~crc;
    w[10:0] = payload;
    for (i = 0; i < 5; i++) w[11 + i] = crc[4 - i];
    if (corrupt) w[13] = ~w[13];
    tx_bytes.delete();
    tx_bytes.push_back(pid_byte(p));
    tx_bytes.push_back(w[7:0]);
    tx_bytes.push_back(w[15:8]);
  endtask

  // CRC16 over every byte after the PID, appended the same way as CRC5
  task automatic append_crc16(input bit corrupt);
    logic [15:0] crc;
    logic [7:0]  lo, hi;
    logic        fb;
    int          k, j;
    crc = '1;
    for (k = 1; k < tx_bytes.size(); k++) begin
      for (j = 0; j < 8; j++) begin
        fb  = tx_bytes[k][j] ^ crc[15];
        crc = {crc[14:0], 1'b0} ^ ({16{fb}} & usb_rx_pkg::Crc16Poly);
      end
    end
    crc = ~crc;
    for (j = 0; j < 8; j++) begin
      lo[j] = crc[15 - j];
      hi[j] = crc[7 - j];
    end
    if (corrupt) hi[0] = ~hi[0];
    tx_bytes.push_back(lo);
    tx_bytes.push_back(hi);
  endtask

  // holds one line state for a bit time, entered and left 2 ns after an edge
  task automatic line_bit(input usb_rx_pkg::usb_line_e l);
    {usb_dp_i, usb_dn_i} = l;
    repeat (4) @(posedge clk_i);
    #2;
  endtask

  // NRZI: a 0 toggles the line, a 1 keeps it
  task automatic send_nrzi(input logic b);
    if (!b) begin
      line_state = (line_state == usb_rx_pkg::LineJ) ? usb_rx_pkg::LineK : usb_rx_pkg::LineJ;
    end
    line_bit(line_state);
  endtask

  task automatic send_packet(input bit stuff_en);
    int ones, k, j;
    ones = 0;
    for (k = 0; k < 7; k++) send_nrzi(1'b0);
    send_nrzi(1'b1);
    for (k = 0; k < tx_bytes.size(); k++) begin
      for (j = 0; j < 8; j++) begin
        send_nrzi(tx_bytes[k][j]);
        ones = tx_bytes[k][j] ? ones + 1 : 0;
        // a stuffed 0 follows every run of six ones
        if (stuff_en && ones == 6) begin
          send_nrzi(1'b0);
          ones = 0;
        end
      end
    end
    line_bit(usb_rx_pkg::LineSe0);
    line_bit(usb_rx_pkg::LineSe0);
    line_state = usb_rx_pkg::LineJ;
    repeat (4) line_bit(usb_rx_pkg::LineJ);
  endtask

  task automatic send_and_wait(input bit stuff_en);
    int waited;
    rx_bytes.delete();
    base_start = start_count;
    base_end   = end_count;
    send_packet(stuff_en);
    waited = 0;
    while (end_count == base_end && waited < 200) begin
      @(posedge clk_i);
      #2;
      waited++;
    end
    if (end_count == base_end) begin
      errors++;
      $display("no end of packet seen within 200 clocks at %0t", $time);
    end
  endtask

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_status(input usb_rx_pkg::usb_rx_status_t got,
                              input usb_rx_pkg::usb_rx_status_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: status got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_pid(input usb_rx_pkg::usb_pid_e got, input usb_rx_pkg::usb_pid_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: pid got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_token(input usb_rx_pkg::usb_token_u got,
                             input usb_rx_pkg::usb_token_u exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: token addr %h endp %h expected addr %h endp %h", $time,
               got.ep.addr, got.ep.endp, exp.ep.addr, exp.ep.endp);
    end
  endtask

  task automatic check_byte(input int idx, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: data byte %0d got %h expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // the judgement shows in the pkt_end_o cycle and stays on status_o
  // until the next packet starts
  task automatic check_packet_status(input usb_rx_pkg::usb_rx_status_t exp);
    check_status(last_status, exp);
    check_status(status_o, exp);
  endtask

  // a clean judgement for a good PID, with the CRC errors as asked
  function automatic usb_rx_pkg::usb_rx_status_t expect_status(
      input usb_rx_pkg::usb_pid_e p, input bit crc5_err, input bit crc16_err);
    usb_rx_pkg::usb_rx_status_t s;
    s              = '0;
    s.pid          = p;
    s.valid_pid    = 1'b1;
    s.crc5_error   = crc5_err;
    s.crc16_error  = crc16_err;
    s.valid_packet = !crc5_err && !crc16_err;
    return s;
  endfunction

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_ack();
    tx_bytes.delete();
    tx_bytes.push_back(pid_byte(usb_rx_pkg::PidAck));
    send_and_wait(1'b1);
    check_count("pkt_start pulses", start_count - base_start, 1);
    check_count("pkt_end pulses", end_count - base_end, 1);
    check_packet_status(expect_status(usb_rx_pkg::PidAck, 1'b0, 1'b0));
    check_count("data bytes after ACK", rx_bytes.size(), 0);
  endtask

  task automatic test_tokens();
    usb_rx_pkg::usb_token_u exp;
    exp.ep.addr = 7'h3a;
    exp.ep.endp = 4'h5;
    build_token(usb_rx_pkg::PidIn, exp, 1'b0);
    send_and_wait(1'b1);
    check_packet_status(expect_status(usb_rx_pkg::PidIn, 1'b0, 1'b0));
    check_token(token_o, exp);
    // SOF carries the same eleven bits read as a frame number
    exp.frame_num = 11'h5a3;
    build_token(usb_rx_pkg::PidSof, exp.frame_num, 1'b0);
    send_and_wait(1'b1);
    check_packet_status(expect_status(usb_rx_pkg::PidSof, 1'b0, 1'b0));
    check_token(token_o, exp);
  endtask

  task automatic test_data();
    int i;
    tx_bytes.delete();
    tx_bytes.push_back(pid_byte(usb_rx_pkg::PidData0));
    for (i = 0; i < 8; i++) begin
      rng_state = xorshift32(rng_state);
      tx_bytes.push_back((i == 2 || i == 5) ? 8'hff : rng_state[7:0]);
    end
    append_crc16(1'b0);
    send_and_wait(1'b1);
    check_packet_status(expect_status(usb_rx_pkg::PidData0, 1'b0, 1'b0));
    // every byte after the PID comes out, the two CRC bytes included
    check_count("data byte count", rx_bytes.size(), tx_bytes.size() - 1);
    for (i = 0; i < rx_bytes.size() && i + 1 < tx_bytes.size(); i++) begin
      check_byte(i, rx_bytes[i], tx_bytes[i + 1]);
    end
  endtask

  task automatic test_crc_errors();
    int i;
    build_token(usb_rx_pkg::PidIn, 11'h123, 1'b1);
    send_and_wait(1'b1);
    check_packet_status(expect_status(usb_rx_pkg::PidIn, 1'b1, 1'b0));
    tx_bytes.delete();
    tx_bytes.push_back(pid_byte(usb_rx_pkg::PidData0));
    for (i = 0; i < 4; i++) begin
      rng_state = xorshift32(rng_state);
      tx_bytes.push_back(rng_state[7:0]);
    end
    append_crc16(1'b1);
    send_and_wait(1'b1);
    check_packet_status(expect_status(usb_rx_pkg::PidData0, 1'b0, 1'b1));
  endtask

  task automatic test_bad_pid();
    usb_rx_pkg::usb_rx_status_t exp;
    tx_bytes.delete();
    // ACK in the low nibble with a check nibble that is not its complement
    tx_bytes.push_back({4'h5, usb_rx_pkg::PidAck});
    send_and_wait(1'b1);
    exp           = '0;
    exp.pid       = usb_rx_pkg::PidAck;
    exp.pid_error = 1'b1;
    check_packet_status(exp);
  endtask

  task automatic test_stuff_error();
    usb_rx_pkg::usb_token_u exp;
    tx_bytes.delete();
    tx_bytes.push_back(pid_byte(usb_rx_pkg::PidData0));
    tx_bytes.push_back(8'hff);
    tx_bytes.push_back(8'hff);
    send_and_wait(1'b0);
    check_pid(last_status.pid, usb_rx_pkg::PidData0);
    check_flag("bitstuff_error", last_status.bitstuff_error, 1'b1);
    check_flag("valid_packet", last_status.valid_packet, 1'b0);
    check_flag("held bitstuff_error", status_o.bitstuff_error, 1'b1);
    // the receiver has to recover for the packet that follows
    exp.ep.addr = 7'h11;
    exp.ep.endp = 4'h2;
    build_token(usb_rx_pkg::PidIn, exp, 1'b0);
    send_and_wait(1'b1);
    check_packet_status(expect_status(usb_rx_pkg::PidIn, 1'b0, 1'b0));
    check_token(token_o, exp);
  endtask

  initial begin
    rst_ni     = 1'b0;
    usb_dp_i   = 1'b1;
    usb_dn_i   = 1'b0;
    line_state = usb_rx_pkg::LineJ;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    repeat (8) line_bit(usb_rx_pkg::LineJ);
    test_ack();
    test_tokens();
    test_data();
    test_crc_errors();
    test_bad_pid();
    test_stuff_error();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
